//--- common/hsdSupervisor_cfg.svh
`ifndef HSD_SUPERVISOR_CFG_SVH
`define HSD_SUPERVISOR_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Register word and index widths
`define GPIO_WIDTH                  32
`define REG_INDEX_WIDTH             3

////////////////////////////////////////////////////////////////////////////
// Register map
`define REG_BUILD_DATE              0
`define REG_MICROSECONDS            1
`define REG_SECONDS                 2
`define REG_USER_STATUS             3
`define REG_INTERLOCK               4
`define REG_SOFT_TRIGGER            5

// Indices at or above this read back as zero
`define REG_COUNT                   6

////////////////////////////////////////////////////////////////////////////
// Triggers
`define TRIGGER_BUS_WIDTH           7
`define EVR_TRIGGER_WIDTH           8

// Top bit of the stretch counter is the stretched software trigger
`define SOFT_TRIGGER_STRETCH_WIDTH  4

////////////////////////////////////////////////////////////////////////////
// Clocking and identification
`define SYSCLK_RATE                 50000000

// Firmware build identification word
`define FIRMWARE_BUILD_DATE         32'h4B1D_7A3C

`endif

//--- common/hsdPkg.sv
`include "hsdSupervisor_cfg.svh"

package hsdPkg;

    ////////////////////////////////////////////////////////////////////////
    // Register access types
    typedef logic [`REG_INDEX_WIDTH-1:0] regIndex_t;
    typedef logic [`GPIO_WIDTH-1:0]      gpioWord_t;

    // Bit 0 is the software trigger, bits 1 to 6 are event triggers 2 to 7
    typedef logic [`TRIGGER_BUS_WIDTH-1:0] triggerBus_t;

    ////////////////////////////////////////////////////////////////////////
    // User status word
    // Raw view for readback, field view for assembly
    typedef union packed {
        gpioWord_t raw;
        struct packed {
            logic                          resetSwitch;
            logic                          displaySwitch;
            logic [4:0]                    reservedHigh;
            logic                          clkLocked;
            logic [`EVR_TRIGGER_WIDTH-1:0] evrTriggers;
            logic [7:0]                    reservedLow;
            logic [7:0]                    dipSwitch;
        } fields;
    } userStatus_u;

endpackage

//--- common/csrBus.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

interface csrBus import hsdPkg::*; ();

    // One-cycle write strobes, one bit per register index
    logic [`REG_COUNT-1:0] strobes;

    // Write data, valid in the same cycle as the strobe
    gpioWord_t             gpioOut;

    // Readback words
    gpioWord_t             microseconds;
    gpioWord_t             seconds;
    userStatus_u           userStatus;
    gpioWord_t             interlockStatus;

    modport control (
        output strobes,
        output gpioOut,
        input  microseconds,
        input  seconds,
        input  userStatus,
        input  interlockStatus
    );

    modport uptime (output microseconds, output seconds);

    modport trigger (input strobes);

    modport panel (output userStatus);

    modport relay (input strobes, input gpioOut, output interlockStatus);

endinterface

//--- src/gpioRegisterFile.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

module gpioRegisterFile import hsdPkg::*; (
    input  logic       sysClk,
    input  logic       rst,
    input  logic       wrStrobe,
    input  regIndex_t  wrAddr,
    input  gpioWord_t  wrData,
    input  regIndex_t  rdAddr,
    output gpioWord_t  rdData,
    csrBus.control     bus
);

    logic [`REG_COUNT-1:0] strobeDecode;
    gpioWord_t             readWord;

    ////////////////////////////////////////////////////////////////////////
    // Write side
    // Decode the index into a one-hot strobe, unknown indices give none
    always_comb begin
        strobeDecode = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            if (wrStrobe && (wrAddr == regIndex_t'(i))) begin
                strobeDecode[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge sysClk) begin
        if (rst) begin
            bus.strobes <= '0;
        end else begin
            bus.strobes <= strobeDecode;
        end
    end

    // Write data lines up with the strobe
    always_ff @(posedge sysClk) begin
        if (wrStrobe) begin
            bus.gpioOut <= wrData;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read side
    always_comb begin
        case (rdAddr)
            regIndex_t'(`REG_BUILD_DATE): begin
                readWord = `FIRMWARE_BUILD_DATE;
            end
            regIndex_t'(`REG_MICROSECONDS): begin
                readWord = bus.microseconds;
            end
            regIndex_t'(`REG_SECONDS): begin
                readWord = bus.seconds;
            end
            regIndex_t'(`REG_USER_STATUS): begin
                readWord = bus.userStatus.raw;
            end
            regIndex_t'(`REG_INTERLOCK): begin
                readWord = bus.interlockStatus;
            end
            // Soft trigger is write only
            default: begin
                readWord = '0;
            end
        endcase
    end

    // Readback follows rdAddr with one cycle of latency
    always_ff @(posedge sysClk) begin
        rdData <= readWord;
    end

endmodule

//--- src/uptimeCounters.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

module uptimeCounters #(
    parameter int CLK_RATE = `SYSCLK_RATE
) (
    input  logic   sysClk,
    input  logic   rst,
    csrBus.uptime  bus
);

    localparam int TICKS_PER_US   = CLK_RATE / 1000000;
    localparam int PRESCALE_WIDTH = $clog2(TICKS_PER_US + 1);
    localparam int US_PER_SECOND  = 1000000;
    localparam int US_WIDTH       = $clog2(US_PER_SECOND);

    logic [PRESCALE_WIDTH-1:0] prescaler;
    logic [US_WIDTH-1:0]       usInSecond;

    ////////////////////////////////////////////////////////////////////////
    // Microsecond prescaler and second rollover
    always_ff @(posedge sysClk) begin
        if (rst) begin
            prescaler        <= PRESCALE_WIDTH'(TICKS_PER_US - 1);
            usInSecond       <= '0;
            bus.microseconds <= '0;
            bus.seconds      <= '0;
        end else if (prescaler == '0) begin
            prescaler        <= PRESCALE_WIDTH'(TICKS_PER_US - 1);
            bus.microseconds <= bus.microseconds + 1'b1;

            // One second every million microseconds
            if (usInSecond == US_WIDTH'(US_PER_SECOND - 1)) begin
                usInSecond  <= '0;
                bus.seconds <= bus.seconds + 1'b1;
            end else begin
                usInSecond <= usInSecond + 1'b1;
            end
        end else begin
            prescaler <= prescaler - 1'b1;
        end
    end

endmodule

//--- src/triggerUnit.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

module triggerUnit import hsdPkg::*; (
    input  logic                          sysClk,
    input  logic                          rst,
    input  logic [`EVR_TRIGGER_WIDTH-1:0] evrTriggers,
    output triggerBus_t                   triggerStrobes,
    csrBus.trigger                        bus
);

    localparam int STRETCH_WIDTH = `SOFT_TRIGGER_STRETCH_WIDTH;

    logic [STRETCH_WIDTH-1:0] stretchCount;
    logic                     softTrigger;
    triggerBus_t              mergedTriggers;
    triggerBus_t              triggerMeta;
    triggerBus_t              triggerSync;
    triggerBus_t              triggerDelay;

    ////////////////////////////////////////////////////////////////////////
    // Software trigger stretcher
    // Load all ones, then count down while the top bit is set
    assign softTrigger = stretchCount[STRETCH_WIDTH-1];

    always_ff @(posedge sysClk) begin
        if (rst) begin
            stretchCount <= '0;
        end else if (bus.strobes[`REG_SOFT_TRIGGER]) begin
            stretchCount <= '1;
        end else if (softTrigger) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    // Event triggers 0 and 1 are heartbeat and PPS, not acquisition triggers
    assign mergedTriggers = {evrTriggers[`EVR_TRIGGER_WIDTH-1:2], softTrigger};

    ////////////////////////////////////////////////////////////////////////
    // Synchronizer and rising edge detect
    always_ff @(posedge sysClk) begin
        if (rst) begin
            triggerMeta    <= '0;
            triggerSync    <= '0;
            triggerDelay   <= '0;
            triggerStrobes <= '0;
        end else begin
            triggerMeta    <= mergedTriggers;
            triggerSync    <= triggerMeta;
            triggerDelay   <= triggerSync;
            triggerStrobes <= triggerSync & ~triggerDelay;
        end
    end

endmodule

//--- src/frontPanel.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

module frontPanel import hsdPkg::*; (
    input  logic                          sysClk,
    input  logic                          rst,
    input  logic                          pmodResetSwitch,
    input  logic                          pmodDisplaySwitch,
    input  logic                          buttonWest,
    input  logic                          buttonEast,
    input  logic                          clkLocked,
    input  logic [`EVR_TRIGGER_WIDTH-1:0] evrTriggers,
    input  logic [7:0]                    dipSwitch,
    csrBus.panel                          bus
);

    logic        resetSwitchMeta;
    logic        resetSwitch;
    logic        displaySwitchMeta;
    logic        displaySwitch;
    userStatus_u status;

    ////////////////////////////////////////////////////////////////////////
    // Operator switches
    // On-board buttons stand in when the front panel is absent
    always_ff @(posedge sysClk) begin
        if (rst) begin
            resetSwitchMeta   <= 1'b0;
            resetSwitch       <= 1'b0;
            displaySwitchMeta <= 1'b0;
            displaySwitch     <= 1'b0;
        end else begin
            resetSwitchMeta   <= !pmodResetSwitch || buttonWest;
            displaySwitchMeta <= !pmodDisplaySwitch || buttonEast;
            resetSwitch       <= resetSwitchMeta;
            displaySwitch     <= displaySwitchMeta;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // User status word
    always_comb begin
        status.fields.resetSwitch   = resetSwitch;
        status.fields.displaySwitch = displaySwitch;
        status.fields.reservedHigh  = '0;
        status.fields.clkLocked     = clkLocked;
        status.fields.evrTriggers   = evrTriggers;
        status.fields.reservedLow   = '0;
        // Serial number of the front end board
        status.fields.dipSwitch     = dipSwitch;
    end

    assign bus.userStatus = status;

endmodule

//--- src/interlock.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

module interlock import hsdPkg::*; (
    input  logic       sysClk,
    input  logic       rst,
    input  logic       pmodResetButton,
    input  logic       pmodRelayOpen,
    input  logic       pmodRelayClosed,
    input  logic       buttonNorth,
    output logic       relayControl,
    output logic [7:0] leds,
    csrBus.relay       bus
);

    logic      resetButton;
    logic      relayOpen;
    logic      relayClosed;
    gpioWord_t statusWord;

    // Relay contacts and the reset button are active low
    assign resetButton = !pmodResetButton || buttonNorth;
    assign relayOpen   = !pmodRelayOpen;
    assign relayClosed = !pmodRelayClosed;

    always_ff @(posedge sysClk) begin
        if (rst) begin
            relayControl <= 1'b0;
        end else if (bus.strobes[`REG_INTERLOCK]) begin
            relayControl <= bus.gpioOut[0];
        end
    end

    assign statusWord = {{(`GPIO_WIDTH-4){1'b0}}, relayClosed, relayOpen,
                         relayControl, resetButton};
    assign bus.interlockStatus = statusWord;

    // Upper nibble mirrors the interlock, lower nibble unused
    assign leds = {resetButton, relayOpen, relayClosed, relayControl, 4'b0};

endmodule

//--- src/hsdSupervisor.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

module hsdSupervisor (
    input  logic                          sysClk,
    input  logic                          rst,

    // Register access
    input  logic                          wrStrobe,
    input  logic [`REG_INDEX_WIDTH-1:0]   wrAddr,
    input  logic [`GPIO_WIDTH-1:0]        wrData,
    input  logic [`REG_INDEX_WIDTH-1:0]   rdAddr,
    output logic [`GPIO_WIDTH-1:0]        rdData,

    // Board inputs
    input  logic [`EVR_TRIGGER_WIDTH-1:0] evrTriggers,
    input  logic                          clkLocked,
    input  logic                          pmodResetSwitch,
    input  logic                          pmodDisplaySwitch,
    input  logic                          pmodResetButton,
    input  logic                          pmodRelayOpen,
    input  logic                          pmodRelayClosed,
    input  logic                          buttonWest,
    input  logic                          buttonEast,
    input  logic                          buttonNorth,
    input  logic [7:0]                    dipSwitch,

    // Board outputs
    output logic [7:0]                    leds,
    output logic                          relayControl,
    output logic [`TRIGGER_BUS_WIDTH-1:0] triggerStrobes
);

    csrBus csr ();

    ////////////////////////////////////////////////////////////////////////
    // Register bank
    gpioRegisterFile i_gpioRegisterFile (
        .sysClk   (sysClk),
        .rst      (rst),
        .wrStrobe (wrStrobe),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .bus      (csr.control)
    );

    ////////////////////////////////////////////////////////////////////////
    // Timekeeping
    uptimeCounters #(
        .CLK_RATE (`SYSCLK_RATE)
    ) i_uptimeCounters (
        .sysClk (sysClk),
        .rst    (rst),
        .bus    (csr.uptime)
    );

    ////////////////////////////////////////////////////////////////////////
    // Triggers, front panel and interlock
    triggerUnit i_triggerUnit (
        .sysClk         (sysClk),
        .rst            (rst),
        .evrTriggers    (evrTriggers),
        .triggerStrobes (triggerStrobes),
        .bus            (csr.trigger)
    );

    frontPanel i_frontPanel (
        .sysClk            (sysClk),
        .rst               (rst),
        .pmodResetSwitch   (pmodResetSwitch),
        .pmodDisplaySwitch (pmodDisplaySwitch),
        .buttonWest        (buttonWest),
        .buttonEast        (buttonEast),
        .clkLocked         (clkLocked),
        .evrTriggers       (evrTriggers),
        .dipSwitch         (dipSwitch),
        .bus               (csr.panel)
    );

    interlock i_interlock (
        .sysClk          (sysClk),
        .rst             (rst),
        .pmodResetButton (pmodResetButton),
        .pmodRelayOpen   (pmodRelayOpen),
        .pmodRelayClosed (pmodRelayClosed),
        .buttonNorth     (buttonNorth),
        .relayControl    (relayControl),
        .leds            (leds),
        .bus             (csr.relay)
    );

endmodule

//--- tb/tbHsdSupervisor.sv
`timescale 1ns/100ps
`include "hsdSupervisor_cfg.svh"

module tbHsdSupervisor import hsdPkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 8;
    localparam int EVENT_LATENCY = 3;
    localparam int UPTIME_CYCLES = 500;
    localparam int RUN_LIMIT     = 2000;

    logic                          sysClk;
    logic                          rst;
    logic                          wrStrobe;
    regIndex_t                     wrAddr;
    gpioWord_t                     wrData;
    regIndex_t                     rdAddr;
    gpioWord_t                     rdData;
    logic [`EVR_TRIGGER_WIDTH-1:0] evrTriggers;
    logic                          clkLocked;
    logic                          pmodResetSwitch;
    logic                          pmodDisplaySwitch;
    logic                          pmodResetButton;
    logic                          pmodRelayOpen;
    logic                          pmodRelayClosed;
    logic                          buttonWest;
    logic                          buttonEast;
    logic                          buttonNorth;
    logic [7:0]                    dipSwitch;
    logic [7:0]                    leds;
    logic                          relayControl;
    triggerBus_t                   triggerStrobes;

    // Model state and bookkeeping
    logic readValid;
    logic expRelay;
    int   seed = 5;
    int   errorCount = 0;

    hsdSupervisor i_dut (
        .sysClk            (sysClk),
        .rst               (rst),
        .wrStrobe          (wrStrobe),
        .wrAddr            (wrAddr),
        .wrData            (wrData),
        .rdAddr            (rdAddr),
        .rdData            (rdData),
        .evrTriggers       (evrTriggers),
        .clkLocked         (clkLocked),
        .pmodResetSwitch   (pmodResetSwitch),
        .pmodDisplaySwitch (pmodDisplaySwitch),
        .pmodResetButton   (pmodResetButton),
        .pmodRelayOpen     (pmodRelayOpen),
        .pmodRelayClosed   (pmodRelayClosed),
        .buttonWest        (buttonWest),
        .buttonEast        (buttonEast),
        .buttonNorth       (buttonNorth),
        .dipSwitch         (dipSwitch),
        .leds              (leds),
        .relayControl      (relayControl),
        .triggerStrobes    (triggerStrobes)
    );

    initial begin
        sysClk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) sysClk = ~sysClk;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    function automatic gpioWord_t expectedWord(regIndex_t index);
        gpioWord_t word;
        word = '0;
        case (index)
            regIndex_t'(`REG_BUILD_DATE): word = `FIRMWARE_BUILD_DATE;
            // Field layout from the top bit down
            regIndex_t'(`REG_USER_STATUS): word = {!pmodResetSwitch || buttonWest,
                !pmodDisplaySwitch || buttonEast, 5'b0, clkLocked, evrTriggers,
                8'b0, dipSwitch};
            regIndex_t'(`REG_INTERLOCK): word = {28'b0, !pmodRelayClosed, !pmodRelayOpen,
                expRelay, !pmodResetButton || buttonNorth};
            // Run is far shorter than one second
            regIndex_t'(`REG_SECONDS): word = '0;
            default: word = '0;
        endcase
        return word;
    endfunction

    function automatic logic [7:0] expectedLeds();
        return {!pmodResetButton || buttonNorth, !pmodRelayOpen, !pmodRelayClosed,
                expRelay, 4'b0};
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic compareWord(gpioWord_t actual, gpioWord_t expected, string what);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] time %0t: %s read 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic compareTriggers(triggerBus_t actual, triggerBus_t expected, string what);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] time %0t: %s strobes 0b%07b, expected 0b%07b",
                     $time, what, actual, expected);
        end
    endtask

    task automatic compareOutputs(logic [7:0] actualLeds, logic actualRelay,
                                  logic [7:0] refLeds, logic refRelay, string what);
        if (actualLeds !== refLeds || actualRelay !== refRelay) begin
            errorCount++;
            $display("[ERROR] time %0t: %s leds 0x%02h relay %b, expected 0x%02h relay %b",
                     $time, what, actualLeds, actualRelay, refLeds, refRelay);
        end
    endtask

    task automatic compareCount(int actual, int expected, string what);
        if (actual != expected) begin
            errorCount++;
            $display("[ERROR] time %0t: %s counted %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // Readback lands one edge after the address is sampled
    always @(posedge sysClk) begin
        regIndex_t sampledAddr;
        gpioWord_t expected;
        if (readValid === 1'b1) begin
            sampledAddr = rdAddr;
            expected    = expectedWord(sampledAddr);
            #1;
            compareWord(rdData, expected, $sformatf("register %0d", sampledAddr));
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    task automatic stepCycle(int cycles);
        repeat (cycles) begin
            @(posedge sysClk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic writeRegister(int index, gpioWord_t data);
        wrStrobe = 1'b1;
        wrAddr   = regIndex_t'(index);
        wrData   = data;
        stepCycle(1);
        wrStrobe = 1'b0;
    endtask

    task automatic issueRead(int index);
        rdAddr    = regIndex_t'(index);
        readValid = 1'b1;
        stepCycle(1);
        readValid = 1'b0;
    endtask

    // Count strobe pulses over a bounded window with an optional second write
    task automatic runSoftTrigger(int writes, int spacing, int window);
        int   pulses;
        logic lastHigh;
        pulses   = 0;
        lastHigh = 1'b0;
        wrAddr   = regIndex_t'(`REG_SOFT_TRIGGER);
        for (int cycle = 0; cycle < window; cycle++) begin
            wrStrobe = (cycle == 0) || (writes > 1 && cycle == spacing);
            wrData   = gpioWord_t'($random(seed));
            stepCycle(1);
            if (triggerStrobes !== '0) begin
                compareTriggers(triggerStrobes, triggerBus_t'(1), "software trigger");
                if (lastHigh) begin
                    errorCount++;
                    $display("[ERROR] time %0t: software trigger strobe high for two cycles",
                             $time);
                end
                pulses++;
            end
            lastHigh = (triggerStrobes !== '0);
            wrStrobe = 1'b0;
        end
        compareCount(pulses, writes, "software trigger pulses");
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        int usFirst;
        int usSecond;
        int usExpected;
        triggerBus_t expected;
        rst               = 1'b1;
        wrStrobe          = 1'b0;
        wrAddr            = '0;
        wrData            = '0;
        rdAddr            = '0;
        readValid         = 1'b0;
        evrTriggers       = '0;
        clkLocked         = 1'b0;
        // Active low board inputs idle high
        pmodResetSwitch   = 1'b1;
        pmodDisplaySwitch = 1'b1;
        pmodResetButton   = 1'b1;
        pmodRelayOpen     = 1'b1;
        pmodRelayClosed   = 1'b1;
        buttonWest        = 1'b0;
        buttonEast        = 1'b0;
        buttonNorth       = 1'b0;
        dipSwitch         = '0;
        expRelay          = 1'b0;
        stepCycle(RESET_CYCLES);
        rst = 1'b0;
        stepCycle(1);
        compareTriggers(triggerStrobes, '0, "after reset");
        compareOutputs(leds, relayControl, expectedLeds(), 1'b0, "after reset");

        // Build date, seconds and indices without a register
        issueRead(`REG_BUILD_DATE);
        issueRead(`REG_SECONDS);
        issueRead(`REG_SOFT_TRIGGER);
        issueRead(6);
        issueRead(7);

        // Interlock writes with random contacts
        repeat (8) begin
            pmodResetButton = 1'($random(seed));
            pmodRelayOpen   = 1'($random(seed));
            pmodRelayClosed = 1'($random(seed));
            buttonNorth     = 1'($random(seed));
            wrData          = gpioWord_t'($random(seed));
            writeRegister(`REG_INTERLOCK, wrData);
            expRelay = wrData[0];
            stepCycle(1);
            compareOutputs(leds, relayControl, expectedLeds(), expRelay, "interlock");
            issueRead(`REG_INTERLOCK);
        end

        // Front panel switches held past the synchronizer
        repeat (8) begin
            pmodResetSwitch   = 1'($random(seed));
            pmodDisplaySwitch = 1'($random(seed));
            buttonWest        = 1'($random(seed));
            buttonEast        = 1'($random(seed));
            clkLocked         = 1'($random(seed));
            dipSwitch         = 8'($random(seed));
            evrTriggers       = 8'($random(seed));
            stepCycle(4);
            issueRead(`REG_USER_STATUS);
        end
        evrTriggers = '0;
        stepCycle(6);

        runSoftTrigger(1, 0, 30);
        runSoftTrigger(2, 12, 40);

        // Each event trigger in turn held high and then released
        for (int k = 0; k < `EVR_TRIGGER_WIDTH; k++) begin
            evrTriggers[k] = 1'b1;
            for (int cycle = 1; cycle <= 10; cycle++) begin
                stepCycle(1);
                expected = '0;
                if (k >= 2 && cycle == EVENT_LATENCY) begin
                    expected = triggerBus_t'(1 << (k - 1));
                end
                compareTriggers(triggerStrobes, expected,
                                $sformatf("event trigger %0d cycle %0d", k, cycle));
            end
            evrTriggers = '0;
            for (int cycle = 1; cycle <= 6; cycle++) begin
                stepCycle(1);
                compareTriggers(triggerStrobes, '0, $sformatf("event trigger %0d falling", k));
            end
        end

        // Microseconds by difference
        rdAddr = regIndex_t'(`REG_MICROSECONDS);
        stepCycle(1);
        usFirst = int'(rdData);
        stepCycle(UPTIME_CYCLES);
        usSecond   = int'(rdData);
        usExpected = UPTIME_CYCLES / (`SYSCLK_RATE / 1000000);
        if (usSecond - usFirst < usExpected - 1 || usSecond - usFirst > usExpected + 1) begin
            errorCount++;
            $display("[ERROR] time %0t: microseconds advanced %0d in %0d cycles, expected %0d",
                     $time, usSecond - usFirst, UPTIME_CYCLES, usExpected);
        end

        $display("Run complete, error count %0d", errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        for (int cycle = 0; cycle < RUN_LIMIT; cycle++) begin
            @(posedge sysClk);
        end
        $display("Timeout: the test sequence did not finish within %0d cycles", RUN_LIMIT);
        $display("Errors found");
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/hsdPkg.sv
common/csrBus.sv
src/gpioRegisterFile.sv
src/uptimeCounters.sv
src/triggerUnit.sv
src/frontPanel.sv
src/interlock.sv
src/hsdSupervisor.sv
tb/tbHsdSupervisor.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tbHsdSupervisor
FILELIST = all.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

# The log decides pass or fail, the simulator exit code does not
run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
